/* glb_load_top.f */
src/glb_load_pkg.sv
src/glb_load_dma.sv
src/glb_bank.sv
src/glb_stream_out.sv
src/glb_load_top.sv
verification/glb_load_tb.sv

/* Bender.yml */
package:
  name: glb_load

sources:
  - src/glb_load_pkg.sv
  - src/glb_load_dma.sv
  - src/glb_bank.sv
  - src/glb_stream_out.sv
  - src/glb_load_top.sv
  - target: test
    files:
      - verification/glb_load_tb.sv

/* verification/glb_load_tb.sv */
`timescale 1ns/1ps

module glb_load_tb;
    import glb_load_pkg::*;

    // what each table entry does after its header write
    localparam int ACT_STREAM = 0;
    localparam int ACT_BUSY = 1;
    localparam int ACT_OFF = 2;
    localparam int ACT_LOAD = 3;
    localparam int ACT_AUTO = 4;

    localparam int WAIT_LIMIT = 40;
    localparam int QUIET_CYCLES = 12;

    typedef struct packed {
        ld_mode_t mode;
        int       slot;
        int       start_addr;
        int       range0;
        int       stride0;
        int       range1;
        int       stride1;
        int       act;
    } desc_t;

    logic clk;
    logic reset;
    ld_mode_t cfg_mode;
    logic cfg_wr;
    logic [$clog2(QUEUE_DEPTH)-1:0] cfg_slot;
    glb_addr_t cfg_start_addr;
    loop_cnt_t cfg_range0;
    stride_t cfg_stride0;
    loop_cnt_t cfg_range1;
    stride_t cfg_stride1;
    logic start;
    logic wr_en;
    glb_addr_t wr_addr;
    row_data_t wr_data;
    logic [QUEUE_DEPTH-1:0] hdr_valid;
    word_data_t stream_data;
    logic stream_valid;
    logic done;

    // local copy of the bank and of the written headers
    row_data_t bank_copy [BANK_ROWS];
    desc_t hdr_copy [QUEUE_DEPTH];
    desc_t desc_q [$];
    word_data_t exp_q [$];
    int cycle_cnt = 0;
    int start_cycle;

    glb_load_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .BANK_LATENCY(BANK_LATENCY)
    ) u_glb_load_top (
        .clk           (clk),
        .reset         (reset),
        .cfg_mode      (cfg_mode),
        .cfg_wr        (cfg_wr),
        .cfg_slot      (cfg_slot),
        .cfg_start_addr(cfg_start_addr),
        .cfg_range0    (cfg_range0),
        .cfg_stride0   (cfg_stride0),
        .cfg_range1    (cfg_range1),
        .cfg_stride1   (cfg_stride1),
        .start         (start),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .hdr_valid     (hdr_valid),
        .stream_data   (stream_data),
        .stream_valid  (stream_valid),
        .done          (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("[ERROR] %s: expected 0x%0h, got 0x%0h", name, exp, got));
        end
    endtask

    // drive and sample 2 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic add_desc(input ld_mode_t mode, input int slot, input int addr,
                            input int r0, input int s0, input int r1, input int s1,
                            input int act);
        desc_q.push_back({mode, slot, addr, r0, s0, r1, s1, act});
    endtask

    // word at byte address a with wrap at the top of the bank
    function automatic word_data_t model_word(input int a);
        int row;
        int sel;
        row = (a & 12'hfff) >> 3;
        sel = ((a & 12'hfff) >> 1) % WORDS_PER_ROW;
        return bank_copy[row][sel*WORD_WIDTH +: WORD_WIDTH];
    endfunction

    task automatic build_expected(input desc_t h);
        exp_q.delete();
        for (int i1 = 0; i1 < h.range1; i1++) begin
            for (int i0 = 0; i0 < h.range0; i0++) begin
                exp_q.push_back(model_word(h.start_addr + 2 * (i0 * h.stride0 + i1 * h.stride1)));
            end
        end
    endtask

    task automatic write_header(input desc_t d);
        tick();
        cfg_wr = 1'b1;
        cfg_slot = d.slot;
        cfg_start_addr = glb_addr_t'(d.start_addr);
        cfg_range0 = loop_cnt_t'(d.range0);
        cfg_stride0 = stride_t'(d.stride0);
        cfg_range1 = loop_cnt_t'(d.range1);
        cfg_stride1 = stride_t'(d.stride1);
        hdr_copy[d.slot] = d;
        tick();
        cfg_wr = 1'b0;
        check_equal("hdr_valid", hdr_valid[d.slot], 1);
    endtask

    task automatic pulse_start();
        tick();
        start = 1'b1;
        start_cycle = cycle_cnt;
        tick();
        start = 1'b0;
    endtask

    // every word must follow the previous one without a gap
    task automatic collect_stream(input int slot, input bit check_lat, input bit extra_start);
        int n;
        int gap;
        build_expected(hdr_copy[slot]);
        n = exp_q.size();
        for (int k = 0; k < n; k++) begin
            gap = 0;
            tick();
            while (!stream_valid) begin
                gap++;
                if (gap > WAIT_LIMIT) begin
                    abort_run($sformatf("timeout: word %0d of %0d from slot %0d never arrived",
                                        k, n, slot));
                end
                tick();
            end
            if (k == 0 && check_lat) begin
                check_equal("stream_valid latency", cycle_cnt - start_cycle, BANK_LATENCY + 3);
            end
            if (k > 0) begin
                check_equal("stream_valid gap", gap, 0);
            end
            check_equal("stream_data", stream_data, exp_q[k]);
            check_equal("done", done, k == n - 1);
            // slot rewritten so that a start while busy finds it valid
            cfg_wr = extra_start && (k == 1);
            start = extra_start && (k == 2);
        end
        cfg_wr = 1'b0;
        start = 1'b0;
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            tick();
            assert (!stream_valid) else begin
                abort_run("unexpected stream word while no stream was running");
            end
        end
    endtask

    initial begin
        desc_t d;
        reset = 1'b1;
        cfg_mode = OFF;
        cfg_wr = 1'b0;
        cfg_slot = '0;
        cfg_start_addr = '0;
        cfg_range0 = '0;
        cfg_stride0 = '0;
        cfg_range1 = '0;
        cfg_stride1 = '0;
        start = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        void'($urandom(42));

        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        tick();
        check_equal("stream_valid", stream_valid, 0);
        check_equal("done", done, 0);
        check_equal("hdr_valid", hdr_valid, 0);

        for (int r = 0; r < BANK_ROWS; r++) begin
            tick();
            wr_en = 1'b1;
            wr_addr = glb_addr_t'(r << ROW_BYTE_BITS);
            wr_data = {$urandom, $urandom};
            bank_copy[r] = wr_data;
        end
        tick();
        wr_en = 1'b0;

        // contiguous, strided, off, busy restart with wrap, then two auto slots
        add_desc(NORMAL, 0, 'h010, 12, 1, 1, 0, ACT_STREAM);
        add_desc(NORMAL, 0, 'h106, 4, 3, 3, 10, ACT_STREAM);
        add_desc(OFF, 0, 'h200, 4, 1, 1, 0, ACT_OFF);
        add_desc(NORMAL, 0, 'hff0, 10, 2, 2, 5, ACT_BUSY);
        add_desc(AUTO_INCR, 0, 'h300, 6, 1, 2, 8, ACT_LOAD);
        add_desc(AUTO_INCR, 1, 'h7fa, 3, 4, 3, 1, ACT_AUTO);

        for (int e = 0; e < desc_q.size(); e++) begin
            d = desc_q[e];
            tick();
            cfg_mode = d.mode;
            write_header(d);
            case (d.act)
                ACT_LOAD: begin
                end
                ACT_OFF: begin
                    pulse_start();
                    check_quiet(QUIET_CYCLES);
                    check_equal("hdr_valid", hdr_valid[d.slot], 1);
                end
                ACT_AUTO: begin
                    pulse_start();
                    for (int s = 0; s < QUEUE_DEPTH; s++) begin
                        collect_stream(s, s == 0, 1'b0);
                    end
                    check_quiet(QUIET_CYCLES);
                    check_equal("hdr_valid", hdr_valid, 0);
                end
                default: begin
                    pulse_start();
                    collect_stream(d.slot, 1'b1, d.act == ACT_BUSY);
                    check_quiet(QUIET_CYCLES);
                    // the busy case leaves its rewritten header unlaunched
                    check_equal("hdr_valid", hdr_valid[d.slot], d.act == ACT_BUSY);
                end
            endcase
            if (d.act != ACT_LOAD) begin
                tick();
                cfg_mode = OFF;
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* src/glb_load_top.sv */
`timescale 1ns/1ps

module glb_load_top #(
    parameter int QUEUE_DEPTH = glb_load_pkg::QUEUE_DEPTH,
    parameter int BANK_LATENCY = glb_load_pkg::BANK_LATENCY
) (
    input  logic                           clk,
    input  logic                           reset,
    input  glb_load_pkg::ld_mode_t         cfg_mode,
    input  logic                           cfg_wr,
    input  logic [$clog2(QUEUE_DEPTH)-1:0] cfg_slot,
    input  glb_load_pkg::glb_addr_t        cfg_start_addr,
    input  glb_load_pkg::loop_cnt_t        cfg_range0,
    input  glb_load_pkg::stride_t          cfg_stride0,
    input  glb_load_pkg::loop_cnt_t        cfg_range1,
    input  glb_load_pkg::stride_t          cfg_stride1,
    input  logic                           start,
    input  logic                           wr_en,
    input  glb_load_pkg::glb_addr_t        wr_addr,
    input  glb_load_pkg::row_data_t        wr_data,
    output logic [QUEUE_DEPTH-1:0]         hdr_valid,
    output glb_load_pkg::word_data_t       stream_data,
    output logic                           stream_valid,
    output logic                           done
);
    import glb_load_pkg::*;

    // producer to consumer
    logic      req_valid;
    glb_addr_t req_addr;
    logic      req_last;

    // producer to bank, bank to consumer
    logic      rd_en;
    glb_addr_t rd_addr;
    row_data_t rd_data;
    logic      rd_data_valid;

    glb_load_dma #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_dma (
        .clk           (clk),
        .reset         (reset),
        .cfg_mode      (cfg_mode),
        .cfg_wr        (cfg_wr),
        .cfg_slot      (cfg_slot),
        .cfg_start_addr(cfg_start_addr),
        .cfg_range0    (cfg_range0),
        .cfg_stride0   (cfg_stride0),
        .cfg_range1    (cfg_range1),
        .cfg_stride1   (cfg_stride1),
        .start         (start),
        .hdr_valid     (hdr_valid),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_last      (req_last),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr)
    );

    glb_bank #(
        .BANK_LATENCY(BANK_LATENCY)
    ) u_bank (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rd_data_valid(rd_data_valid)
    );

    glb_stream_out #(
        .BANK_LATENCY(BANK_LATENCY)
    ) u_out (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_last     (req_last),
        .rd_data      (rd_data),
        .rd_data_valid(rd_data_valid),
        .stream_data  (stream_data),
        .stream_valid (stream_valid),
        .done         (done)
    );

endmodule

/* src/glb_stream_out.sv */
`timescale 1ns/1ps

module glb_stream_out #(
    parameter int BANK_LATENCY = glb_load_pkg::BANK_LATENCY
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    input  glb_load_pkg::glb_addr_t   req_addr,
    input  logic                      req_last,
    input  glb_load_pkg::row_data_t   rd_data,
    input  logic                      rd_data_valid,
    output glb_load_pkg::word_data_t  stream_data,
    output logic                      stream_valid,
    output logic                      done
);
    import glb_load_pkg::*;

    localparam int SEL_W = $clog2(WORDS_PER_ROW);

    // request info delayed to line up with bank data
    logic [BANK_LATENCY-1:0] valid_d;
    logic [BANK_LATENCY-1:0] last_d;
    glb_addr_t addr_d [BANK_LATENCY];

    row_data_t row_cache;
    row_data_t row_cur;
    logic [SEL_W-1:0] word_sel;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_d <= '0;
            last_d <= '0;
        end else begin
            valid_d[0] <= req_valid;
            last_d[0] <= req_last;
            for (int i = 1; i < BANK_LATENCY; i++) begin
                valid_d[i] <= valid_d[i-1];
                last_d[i] <= last_d[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_d[0] <= req_addr;
        for (int i = 1; i < BANK_LATENCY; i++) begin
            addr_d[i] <= addr_d[i-1];
        end
    end

    // rows only arrive on a row change, later words reuse the cache
    always_ff @(posedge clk) begin
        if (rd_data_valid) begin
            row_cache <= rd_data;
        end
    end

    assign row_cur = rd_data_valid ? rd_data : row_cache;
    assign word_sel = addr_d[BANK_LATENCY-1][WORD_BYTE_BITS +: SEL_W];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stream_valid <= 1'b0;
            done <= 1'b0;
        end else begin
            stream_valid <= valid_d[BANK_LATENCY-1];
            done <= valid_d[BANK_LATENCY-1] & last_d[BANK_LATENCY-1];
        end
    end

    always_ff @(posedge clk) begin
        if (valid_d[BANK_LATENCY-1]) begin
            stream_data <= row_cur[word_sel*WORD_WIDTH +: WORD_WIDTH];
        end
    end

    // a stream ends with done on its last word, and the relaunch leaves a gap
    a_done_closes_stream: assert property (@(posedge clk) disable iff (reset)
        done |-> stream_valid ##1 !stream_valid);

endmodule

/* src/glb_bank.sv */
`timescale 1ns/1ps

module glb_bank #(
    parameter int BANK_LATENCY = glb_load_pkg::BANK_LATENCY
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr_en,
    input  glb_load_pkg::glb_addr_t  wr_addr,
    input  glb_load_pkg::row_data_t  wr_data,
    input  logic                     rd_en,
    input  glb_load_pkg::glb_addr_t  rd_addr,
    output glb_load_pkg::row_data_t  rd_data,
    output logic                     rd_data_valid
);
    import glb_load_pkg::*;

    row_data_t mem [BANK_ROWS];

    // read pipeline, one stage per cycle of latency
    row_data_t data_pipe [BANK_LATENCY];
    logic [BANK_LATENCY-1:0] valid_pipe;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[GLB_ADDR_WIDTH-1:ROW_BYTE_BITS]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            data_pipe[0] <= mem[rd_addr[GLB_ADDR_WIDTH-1:ROW_BYTE_BITS]];
        end
        for (int i = 1; i < BANK_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= rd_en;
            for (int i = 1; i < BANK_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    assign rd_data = data_pipe[BANK_LATENCY-1];
    assign rd_data_valid = valid_pipe[BANK_LATENCY-1];

    // preload and streaming must not overlap
    a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (reset)
        !(rd_en && wr_en));

endmodule

/* src/glb_load_dma.sv */
`timescale 1ns/1ps

module glb_load_dma #(
    parameter int QUEUE_DEPTH = glb_load_pkg::QUEUE_DEPTH
) (
    input  logic                           clk,
    input  logic                           reset,
    input  glb_load_pkg::ld_mode_t         cfg_mode,
    input  logic                           cfg_wr,
    input  logic [$clog2(QUEUE_DEPTH)-1:0] cfg_slot,
    input  glb_load_pkg::glb_addr_t        cfg_start_addr,
    input  glb_load_pkg::loop_cnt_t        cfg_range0,
    input  glb_load_pkg::stride_t          cfg_stride0,
    input  glb_load_pkg::loop_cnt_t        cfg_range1,
    input  glb_load_pkg::stride_t          cfg_stride1,
    input  logic                           start,
    output logic [QUEUE_DEPTH-1:0]         hdr_valid,
    output logic                           req_valid,
    output glb_load_pkg::glb_addr_t        req_addr,
    output logic                           req_last,
    output logic                           rd_en,
    output glb_load_pkg::glb_addr_t        rd_addr
);
    import glb_load_pkg::*;

    // lowest address bit that selects a bank row
    localparam int ROW_LSB = WORD_BYTE_BITS + $clog2(WORDS_PER_ROW);

    typedef enum logic {
        IDLE,
        RUN
    } state_t;

    state_t state;

    // header queue
    glb_addr_t hdr_start [QUEUE_DEPTH];
    loop_cnt_t hdr_range0 [QUEUE_DEPTH];
    stride_t   hdr_stride0 [QUEUE_DEPTH];
    loop_cnt_t hdr_range1 [QUEUE_DEPTH];
    stride_t   hdr_stride1 [QUEUE_DEPTH];

    logic [$clog2(QUEUE_DEPTH)-1:0] q_sel;
    logic armed;
    logic trigger;
    logic launch;
    logic launch_next;

    // working copy of the running header
    glb_addr_t start_r;
    loop_cnt_t range0_r;
    stride_t   stride0_r;
    loop_cnt_t range1_r;
    stride_t   stride1_r;
    loop_cnt_t i0;
    loop_cnt_t i1;

    // request being issued this cycle
    glb_addr_t cur_start;
    loop_cnt_t cur_range0;
    stride_t   cur_stride0;
    loop_cnt_t cur_range1;
    stride_t   cur_stride1;
    loop_cnt_t idx0;
    loop_cnt_t idx1;
    logic [LOOP_CNT_WIDTH+STRIDE_WIDTH:0] word_off;
    glb_addr_t addr;
    logic issue;
    logic inner_wrap;
    logic last;

    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            hdr_start[cfg_slot] <= cfg_start_addr;
            hdr_range0[cfg_slot] <= cfg_range0;
            hdr_stride0[cfg_slot] <= cfg_stride0;
            hdr_range1[cfg_slot] <= cfg_range1;
            hdr_stride1[cfg_slot] <= cfg_stride1;
        end
    end

    // a fresh write wins over the launch clear
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hdr_valid <= '0;
        end else begin
            if (launch) begin
                hdr_valid[q_sel] <= 1'b0;
            end
            if (cfg_wr) begin
                hdr_valid[cfg_slot] <= 1'b1;
            end
        end
    end

    // auto-incr stays armed until the mode changes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            armed <= 1'b0;
        end else if (cfg_mode != AUTO_INCR) begin
            armed <= 1'b0;
        end else if (start) begin
            armed <= 1'b1;
        end
    end

    always_comb begin
        case (cfg_mode)
            NORMAL:    trigger = start;
            AUTO_INCR: trigger = start | armed;
            default:   trigger = 1'b0;
        endcase
    end

    assign launch_next = trigger & (state == IDLE) & ~launch & hdr_valid[q_sel];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            launch <= 1'b0;
        end else begin
            launch <= launch_next;
        end
    end

    // slot pointer moves only in auto-incr
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_sel <= '0;
        end else if (cfg_mode != AUTO_INCR) begin
            q_sel <= '0;
        end else if (issue && last) begin
            q_sel <= (q_sel == QUEUE_DEPTH - 1) ? '0 : q_sel + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            start_r <= hdr_start[q_sel];
            range0_r <= hdr_range0[q_sel];
            stride0_r <= hdr_stride0[q_sel];
            range1_r <= hdr_range1[q_sel];
            stride1_r <= hdr_stride1[q_sel];
        end
    end

    // the launch cycle issues request zero straight from the queue
    always_comb begin
        if (launch) begin
            cur_start = hdr_start[q_sel];
            cur_range0 = hdr_range0[q_sel];
            cur_stride0 = hdr_stride0[q_sel];
            cur_range1 = hdr_range1[q_sel];
            cur_stride1 = hdr_stride1[q_sel];
            idx0 = '0;
            idx1 = '0;
        end else begin
            cur_start = start_r;
            cur_range0 = range0_r;
            cur_stride0 = stride0_r;
            cur_range1 = range1_r;
            cur_stride1 = stride1_r;
            idx0 = i0;
            idx1 = i1;
        end
        word_off = idx0 * cur_stride0 + idx1 * cur_stride1;
        addr = cur_start + glb_addr_t'(word_off << WORD_BYTE_BITS);
        inner_wrap = (idx0 == loop_cnt_t'(cur_range0 - 1'b1));
        last = inner_wrap && (idx1 == loop_cnt_t'(cur_range1 - 1'b1));
    end

    assign issue = launch | (state == RUN);

    // two-level counter with carry from inner into outer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            i0 <= '0;
            i1 <= '0;
        end else if (issue) begin
            if (last) begin
                state <= IDLE;
                i0 <= '0;
                i1 <= '0;
            end else begin
                state <= RUN;
                if (inner_wrap) begin
                    i0 <= '0;
                    i1 <= idx1 + 1'b1;
                end else begin
                    i0 <= idx0 + 1'b1;
                    i1 <= idx1;
                end
            end
        end
    end

    // bank read only on the first request or when the row changes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_valid <= 1'b0;
            req_last <= 1'b0;
            rd_en <= 1'b0;
        end else begin
            req_valid <= issue;
            req_last <= issue & last;
            rd_en <= issue & (launch |
                (addr[GLB_ADDR_WIDTH-1:ROW_LSB] != req_addr[GLB_ADDR_WIDTH-1:ROW_LSB]));
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr <= addr;
        end
    end

    assign rd_addr = req_addr;

    a_launch_from_idle: assert property (@(posedge clk) disable iff (reset)
        launch |-> state == IDLE);

endmodule

/* src/glb_load_pkg.sv */
package glb_load_pkg;

    // datapath widths
    localparam int GLB_ADDR_WIDTH = 12;
    localparam int ROW_WIDTH = 64;
    localparam int WORD_WIDTH = 16;
    localparam int LOOP_CNT_WIDTH = 8;
    localparam int STRIDE_WIDTH = 8;

    // default structure of the load path
    localparam int BANK_LATENCY = 2;
    localparam int QUEUE_DEPTH = 2;

    // derived address geometry
    localparam int WORD_BYTE_BITS = $clog2(WORD_WIDTH / 8);
    localparam int ROW_BYTE_BITS = $clog2(ROW_WIDTH / 8);
    localparam int WORDS_PER_ROW = ROW_WIDTH / WORD_WIDTH;
    localparam int BANK_ROWS = 2 ** (GLB_ADDR_WIDTH - ROW_BYTE_BITS);

    // byte address into the bank
    typedef logic [GLB_ADDR_WIDTH-1:0] glb_addr_t;

    // one bank row
    typedef logic [ROW_WIDTH-1:0] row_data_t;

    // one word to the fabric
    typedef logic [WORD_WIDTH-1:0] word_data_t;

    // loop range and loop index
    typedef logic [LOOP_CNT_WIDTH-1:0] loop_cnt_t;

    // stride in words
    typedef logic [STRIDE_WIDTH-1:0] stride_t;

    // load modes, code 2 is unused here
    typedef enum logic [1:0] {
        OFF       = 2'd0,
        NORMAL    = 2'd1,
        AUTO_INCR = 2'd3
    } ld_mode_t;

endpackage
